/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = datapath_tb
FILELIST  = datapath.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/datapath_properties.sv */
// Memory port assertions
`timescale 1ns/10ps

module datapath_properties (
    input logic                 CLK,
    input logic                 reset,
    input logic                 dmem_ren,
    input logic                 dmem_wen,
    input logic                 halt,
    input cpu_types_pkg::word_t imemaddr
);
    // Read and write never together
    assert property (@(posedge CLK) disable iff (reset) !(dmem_ren && dmem_wen))
        else $error("dmem_ren and dmem_wen both high");

    // Sticky halt
    assert property (@(posedge CLK) disable iff (reset) halt |=> halt)
        else $error("halt fell without reset");

    assert property (@(posedge CLK) disable iff (reset) halt |-> !(dmem_ren || dmem_wen))
        else $error("data request after halt");

    assert property (@(posedge CLK) disable iff (reset) imemaddr[1:0] == 2'b00)
        else $error("imemaddr not word-aligned");

endmodule

bind datapath datapath_properties i_datapath_properties (
    .CLK(CLK), .reset(reset), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .halt(halt), .imemaddr(imemaddr)
);

/* bench/datapath_tb.sv */
// Pipelined datapath testbench
`timescale 1ns/10ps
`include "cpu_consts.svh"

module datapath_tb;
    localparam int PROG_LEN   = 60;
    localparam int TAIL_START = PROG_LEN;
    localparam int MAX_CYCLES = (PROG_LEN + 32 + 8) * 5 * 4 + 500;

    logic                 CLK = 1'b0;
    logic                 reset, ihit, dhit, imem_ren, dmem_ren, dmem_wen, halt;
    cpu_types_pkg::word_t imemload, dmemload, imemaddr, dmemaddr, dmemstore;

    cpu_types_pkg::word_t imem [256];
    cpu_types_pkg::word_t dmem [cpu_types_pkg::word_t];
    cpu_types_pkg::word_t mdl_mem [cpu_types_pkg::word_t];
    cpu_types_pkg::word_t mdl_reg [32];
    cpu_types_pkg::word_t exp_addr [$];
    cpu_types_pkg::word_t exp_data [$];
    cpu_types_pkg::word_t rng_state = 32'h1a6d035a;
    int errors = 0;
    int store_count = 0;
    int model_stores = 0;
    int cycles = 0;
    int i_wait = 0;
    int d_wait = 0;

    datapath i_datapath (
        .CLK(CLK), .reset(reset), .ihit(ihit), .imemload(imemload), .dhit(dhit),
        .dmemload(dmemload), .imem_ren(imem_ren), .imemaddr(imemaddr),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmemaddr(dmemaddr),
        .dmemstore(dmemstore), .halt(halt)
    );

    always #10 CLK = ~CLK;

    function automatic cpu_types_pkg::word_t next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    // Unwritten memory reads a pattern of the full address
    function automatic cpu_types_pkg::word_t fill_word(cpu_types_pkg::word_t a);
        return (a * 32'h9e3779b1) ^ 32'h1234_5678;
    endfunction

    function automatic cpu_types_pkg::word_t enc_r(logic [5:0] f, logic [4:0] rs,
                                                   logic [4:0] rt, logic [4:0] rd);
        return {6'b000000, rs, rt, rd, 5'b00000, f};
    endfunction

    function automatic cpu_types_pkg::word_t enc_i(logic [5:0] op, logic [4:0] rs,
                                                   logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_word(string name, cpu_types_pkg::word_t got,
                              cpu_types_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Random program with forward-only control flow, then register dump and HALT
    task automatic build_program();
        int i;
        int k;
        int t;
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rc;
        logic [5:0] f;
        for (int a = 0; a < 256; a++) begin
            imem[a] = '0;
        end
        i = 0;
        while (i < PROG_LEN) begin
            k = rand_below(10);
            ra = 5'(1 + rand_below(8));
            rb = 5'(1 + rand_below(8));
            rc = 5'(1 + rand_below(8));
            t = i + 2 + rand_below(4);
            if (t > TAIL_START) begin
                t = TAIL_START;
            end
            case (k)
                0: begin
                    case (rand_below(5))
                        0: f = cpu_types_pkg::ADDU;
                        1: f = cpu_types_pkg::SUBU;
                        2: f = cpu_types_pkg::AND;
                        3: f = cpu_types_pkg::OR;
                        default: f = cpu_types_pkg::SLT;
                    endcase
                    imem[i] = enc_r(f, ra, rb, rc);
                end
                1: imem[i] = enc_i(cpu_types_pkg::ADDIU, ra, rb, 16'(next_rand()));
                2: imem[i] = enc_i(cpu_types_pkg::ORI, ra, rb, 16'(next_rand()));
                3: imem[i] = enc_i(cpu_types_pkg::LUI, 5'd0, rb, 16'(next_rand()));
                4: imem[i] = enc_i(cpu_types_pkg::SW, 5'd0, rb, 16'(256 + 4 * rand_below(16)));
                5: begin
                    imem[i] = enc_i(cpu_types_pkg::LW, 5'd0, rb, 16'(256 + 4 * rand_below(16)));
                    // Load followed directly by a use
                    if (i < PROG_LEN - 1) begin
                        i++;
                        imem[i] = enc_r(cpu_types_pkg::ADDU, rb, ra, rc);
                    end
                end
                6: begin
                    imem[i] = enc_i(rand_below(2) == 0 ? cpu_types_pkg::BEQ : cpu_types_pkg::BNE,
                                    ra, rb, 16'(t - i - 1));
                end
                7: begin
                    imem[i] = {rand_below(2) == 0 ? cpu_types_pkg::J : cpu_types_pkg::JAL,
                               26'(t)};
                end
                8: begin
                    // Target setup right before JR forces a decode stall
                    if (i < PROG_LEN - 1) begin
                        imem[i] = enc_i(cpu_types_pkg::ADDIU, 5'd0, 5'd9, 16'(4 * (t + 1)));
                        i++;
                        imem[i] = enc_r(cpu_types_pkg::JR, 5'd9, 5'd0, 5'd0);
                    end
                end
                default: imem[i] = enc_i(cpu_types_pkg::ADDIU, ra, ra, 16'(next_rand()));
            endcase
            i++;
        end
        for (int r = 1; r < 32; r++) begin
            imem[TAIL_START + r - 1] = enc_i(cpu_types_pkg::SW, 5'd0, 5'(r), 16'(1024 + 4 * r));
        end
        imem[TAIL_START + 31] = 32'hffff_ffff;
    endtask

    // Instruction-level reference, one instruction at a time in program order
    task automatic run_model();
        cpu_types_pkg::word_t pc;
        cpu_types_pkg::word_t ins;
        cpu_types_pkg::word_t a;
        cpu_types_pkg::word_t b;
        cpu_types_pkg::word_t simm;
        cpu_types_pkg::word_t zimm;
        cpu_types_pkg::word_t ea;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic done;
        pc = `CPU_PC_INIT;
        done = 1'b0;
        for (int r = 0; r < 32; r++) begin
            mdl_reg[r] = '0;
        end
        for (int step = 0; step < 1000 && !done; step++) begin
            ins  = imem[pc[9:2]];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            a    = mdl_reg[rs];
            b    = mdl_reg[rt];
            simm = {{16{ins[15]}}, ins[15:0]};
            zimm = {16'h0000, ins[15:0]};
            ea   = a + simm;
            pc   = pc + 4;
            case (ins[31:26])
                6'b000000: begin
                    case (ins[5:0])
                        6'b100001: mdl_reg[rd] = a + b;
                        6'b100011: mdl_reg[rd] = a - b;
                        6'b100100: mdl_reg[rd] = a & b;
                        6'b100101: mdl_reg[rd] = a | b;
                        6'b101010: mdl_reg[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'b001000: pc = a;
                        default: ;
                    endcase
                end
                6'b001001: mdl_reg[rt] = a + simm;
                6'b001101: mdl_reg[rt] = a | zimm;
                6'b001111: mdl_reg[rt] = {ins[15:0], 16'h0000};
                6'b100011: mdl_reg[rt] = mdl_mem.exists(ea) ? mdl_mem[ea] : fill_word(ea);
                6'b101011: begin
                    mdl_mem[ea] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                    model_stores++;
                end
                6'b000100: if (a == b) pc = pc + (simm << 2);
                6'b000101: if (a != b) pc = pc + (simm << 2);
                6'b000010: pc = {pc[31:28], ins[25:0], 2'b00};
                6'b000011: begin
                    mdl_reg[31] = pc;
                    pc = {pc[31:28], ins[25:0], 2'b00};
                end
                6'b111111: done = 1'b1;
                default: ;
            endcase
            mdl_reg[0] = '0;
        end
        if (!done) begin
            $display("Reference model did not reach HALT");
            errors++;
        end
    endtask

    // Memory models with random hit latency, driven on the falling edge
    always @(negedge CLK) begin
        logic req;
        logic adv;
        req = dmem_ren || dmem_wen;
        check_bit("imem_ren", imem_ren, 1'b1);
        ihit     = (i_wait == 0);
        imemload = imem[imemaddr[9:2]];
        dhit     = req && (d_wait == 0);
        dmemload = (dhit && dmem_ren) ?
                   (dmem.exists(dmemaddr) ? dmem[dmemaddr] : fill_word(dmemaddr)) : '0;
        adv = ihit && (!req || dhit);
        if (!ihit) begin
            i_wait--;
        end else if (adv) begin
            i_wait = rand_below(4);
        end
        if (req && !dhit) begin
            d_wait--;
        end else if (req && adv) begin
            if (dmem_wen) begin
                dmem[dmemaddr] = dmemstore;
                store_count++;
                if (exp_addr.size() == 0) begin
                    $display("Store at %0t to %h not expected by the model", $time, dmemaddr);
                    errors++;
                end else begin
                    check_word("dmemaddr", dmemaddr, exp_addr.pop_front());
                    check_word("dmemstore", dmemstore, exp_data.pop_front());
                end
            end
            d_wait = rand_below(4);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: halt did not rise within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        ihit     = 1'b0;
        dhit     = 1'b0;
        imemload = '0;
        dmemload = '0;
        build_program();
        run_model();
        repeat (10) @(negedge CLK);
        reset = 1'b0;
        check_bit("halt", halt, 1'b0);
        check_bit("dmem_ren", dmem_ren, 1'b0);
        check_bit("dmem_wen", dmem_wen, 1'b0);
        check_word("imemaddr", imemaddr, `CPU_PC_INIT);
        while (!halt) begin
            @(negedge CLK);
        end
        repeat (10) begin
            @(negedge CLK);
            check_bit("halt", halt, 1'b1);
            check_bit("dmem_ren", dmem_ren, 1'b0);
            check_bit("dmem_wen", dmem_wen, 1'b0);
        end
        check_word("store_count", store_count, model_stores);
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never reached the data port", exp_addr.size());
            errors++;
        end
        foreach (mdl_mem[a]) begin
            check_word("dmem", dmem.exists(a) ? dmem[a] : fill_word(a), mdl_mem[a]);
        end
        $display("Run complete: %0d stores, %0d errors", store_count, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* datapath.f */
+incdir+logic
logic/cpu_types_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/control_unit.sv
logic/hazard_unit.sv
logic/datapath.sv
bench/datapath_properties.sv
bench/datapath_tb.sv

/* logic/alu.sv */
// Arithmetic logic unit
`timescale 1ns/10ps

module alu (
    input  cpu_types_pkg::word_t   port_a,
    input  cpu_types_pkg::word_t   port_b,
    input  cpu_types_pkg::aluop_t  alu_op,
    output cpu_types_pkg::word_t   out_port
);
    always_comb begin
        case (alu_op)
            cpu_types_pkg::ALU_ADD: out_port = port_a + port_b;
            cpu_types_pkg::ALU_SUB: out_port = port_a - port_b;
            cpu_types_pkg::ALU_AND: out_port = port_a & port_b;
            cpu_types_pkg::ALU_OR:  out_port = port_a | port_b;
            // Signed compare
            cpu_types_pkg::ALU_SLT: begin
                out_port = ($signed(port_a) < $signed(port_b)) ? 32'd1 : 32'd0;
            end
            // Immediate moves to the upper half
            cpu_types_pkg::ALU_LUI: out_port = {port_b[15:0], 16'h0000};
            default:                out_port = '0;
        endcase
    end

endmodule

/* logic/control_unit.sv */
// Instruction decoder
`timescale 1ns/10ps

module control_unit (
    input  cpu_types_pkg::opcode_t opcode,
    input  cpu_types_pkg::funct_t  funct,
    output logic                   reg_dst,
    output logic                   alu_src,
    output logic                   ext_signed,
    output logic                   mem_to_reg,
    output logic                   reg_wen,
    output logic                   dmem_ren,
    output logic                   dmem_wen,
    output logic                   branch_eq,
    output logic                   branch_ne,
    output logic                   jump,
    output logic                   jump_link,
    output logic                   jump_reg,
    output logic                   halt_op,
    output cpu_types_pkg::aluop_t  alu_op
);
    always_comb begin
        // Unknown codes fall through as no-operations
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        ext_signed = 1'b0;
        mem_to_reg = 1'b0;
        reg_wen    = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        branch_eq  = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        jump_link  = 1'b0;
        jump_reg   = 1'b0;
        halt_op    = 1'b0;
        alu_op     = cpu_types_pkg::ALU_ADD;
        case (opcode)
            cpu_types_pkg::RTYPE: begin
                reg_dst = 1'b1;
                reg_wen = 1'b1;
                case (funct)
                    cpu_types_pkg::ADDU: alu_op = cpu_types_pkg::ALU_ADD;
                    cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
                    cpu_types_pkg::AND:  alu_op = cpu_types_pkg::ALU_AND;
                    cpu_types_pkg::OR:   alu_op = cpu_types_pkg::ALU_OR;
                    cpu_types_pkg::SLT:  alu_op = cpu_types_pkg::ALU_SLT;
                    cpu_types_pkg::JR: begin
                        reg_dst  = 1'b0;
                        reg_wen  = 1'b0;
                        jump_reg = 1'b1;
                    end
                    default: begin
                        reg_dst = 1'b0;
                        reg_wen = 1'b0;
                    end
                endcase
            end
            cpu_types_pkg::ADDIU: begin
                alu_src    = 1'b1;
                ext_signed = 1'b1;
                reg_wen    = 1'b1;
            end
            cpu_types_pkg::ORI: begin
                alu_src = 1'b1;
                reg_wen = 1'b1;
                alu_op  = cpu_types_pkg::ALU_OR;
            end
            cpu_types_pkg::LUI: begin
                alu_src = 1'b1;
                reg_wen = 1'b1;
                alu_op  = cpu_types_pkg::ALU_LUI;
            end
            cpu_types_pkg::LW: begin
                alu_src    = 1'b1;
                ext_signed = 1'b1;
                mem_to_reg = 1'b1;
                reg_wen    = 1'b1;
                dmem_ren   = 1'b1;
            end
            cpu_types_pkg::SW: begin
                alu_src    = 1'b1;
                ext_signed = 1'b1;
                dmem_wen   = 1'b1;
            end
            // Branch offsets are signed
            cpu_types_pkg::BEQ: begin
                ext_signed = 1'b1;
                branch_eq  = 1'b1;
            end
            cpu_types_pkg::BNE: begin
                ext_signed = 1'b1;
                branch_ne  = 1'b1;
            end
            cpu_types_pkg::J:    jump = 1'b1;
            cpu_types_pkg::JAL: begin
                jump      = 1'b1;
                jump_link = 1'b1;
                reg_wen   = 1'b1;
            end
            cpu_types_pkg::HALT: halt_op = 1'b1;
            default: ;
        endcase
    end

endmodule

/* logic/cpu_consts.svh */
// CPU constants
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address word width
`define CPU_WORD_W 32

// Architectural register count, register 0 included
`define CPU_REG_COUNT 32

// First fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

`endif

/* logic/cpu_types_pkg.sv */
// CPU type definitions
package cpu_types_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] regbits_t;

    // Major opcodes of the supported subset
    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        ADDIU = 6'b001001,
        ORI   = 6'b001101,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        HALT  = 6'b111111
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        JR   = 6'b001000,
        ADDU = 6'b100001,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        SLT  = 6'b101010
    } funct_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } aluop_t;

endpackage

/* logic/datapath.sv */
// Five-stage pipelined datapath
`timescale 1ns/10ps
`include "cpu_consts.svh"

module datapath (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 ihit,
    input  cpu_types_pkg::word_t imemload,
    input  logic                 dhit,
    input  cpu_types_pkg::word_t dmemload,
    output logic                 imem_ren,
    output cpu_types_pkg::word_t imemaddr,
    output logic                 dmem_ren,
    output logic                 dmem_wen,
    output cpu_types_pkg::word_t dmemaddr,
    output cpu_types_pkg::word_t dmemstore,
    output logic                 halt
);
    cpu_types_pkg::word_t    pc, pc_plus4, next_pc;
    logic                    advance, stall, redirect, fetch_stop;
    // IF/ID
    logic                    ifid_valid;
    cpu_types_pkg::word_t    ifid_instr, ifid_pc4;
    // ID/EX
    logic                    idex_valid, idex_alu_src, idex_mem_to_reg, idex_reg_wen;
    logic                    idex_dren, idex_dwen, idex_link, idex_halt;
    cpu_types_pkg::aluop_t   idex_alu_op;
    cpu_types_pkg::word_t    idex_pc4, idex_rdat1, idex_rdat2, idex_imm;
    cpu_types_pkg::regbits_t idex_rs, idex_rt, idex_dest;
    // EX/MEM
    logic                    exmem_valid, exmem_mem_to_reg, exmem_reg_wen;
    logic                    exmem_dren, exmem_dwen, exmem_link, exmem_halt;
    cpu_types_pkg::word_t    exmem_pc4, exmem_alu, exmem_store;
    cpu_types_pkg::regbits_t exmem_dest;
    // MEM/WB
    logic                    memwb_valid, memwb_mem_to_reg, memwb_reg_wen;
    logic                    memwb_link, memwb_halt;
    cpu_types_pkg::word_t    memwb_pc4, memwb_alu, memwb_dload;
    cpu_types_pkg::regbits_t memwb_dest;
    // Decode
    cpu_types_pkg::regbits_t id_rs, id_rt, id_rd, id_dest;
    logic                    reg_dst, alu_src, ext_signed, mem_to_reg, reg_wen;
    logic                    id_dren, id_dwen, branch_eq, branch_ne;
    logic                    jump, jump_link, jump_reg, halt_op;
    logic                    branch_taken, load_stall, branch_stall;
    cpu_types_pkg::aluop_t   alu_op;
    cpu_types_pkg::word_t    rdat1, rdat2, id_imm, branch_target, jump_target;
    // Execute and writeback
    logic [1:0]              forward_a, forward_b;
    cpu_types_pkg::word_t    alu_a, fwd_b, alu_b, alu_out, mem_result, wb_data;

    // Frozen while fetch misses or a data request waits for its hit
    assign advance = ihit && (!(exmem_valid && (exmem_dren || exmem_dwen)) || dhit);

    assign pc_plus4 = pc + 32'd4;
    assign id_rs    = ifid_instr[25:21];
    assign id_rt    = ifid_instr[20:16];
    assign id_rd    = ifid_instr[15:11];
    assign id_dest  = jump_link ? 5'd31 : (reg_dst ? id_rd : id_rt);
    assign id_imm   = ext_signed ? {{(`CPU_WORD_W-16){ifid_instr[15]}}, ifid_instr[15:0]}
                                 : {{(`CPU_WORD_W-16){1'b0}}, ifid_instr[15:0]};

    // Branches and jumps resolve in decode
    assign branch_target = ifid_pc4 + {id_imm[29:0], 2'b00};
    assign jump_target   = {ifid_pc4[31:28], ifid_instr[25:0], 2'b00};
    assign stall         = ifid_valid && (load_stall || branch_stall);
    assign branch_taken  = (branch_eq && rdat1 == rdat2) || (branch_ne && rdat1 != rdat2);
    assign redirect      = ifid_valid && !stall && (branch_taken || jump || jump_reg);

    // No fetch past a HALT
    assign fetch_stop = (ifid_valid && halt_op) || (idex_valid && idex_halt) ||
                        (exmem_valid && exmem_halt) || (memwb_valid && memwb_halt) || halt;

    always_comb begin
        if (!redirect) begin
            next_pc = pc_plus4;
        end else if (jump_reg) begin
            next_pc = rdat1;
        end else if (jump) begin
            next_pc = jump_target;
        end else begin
            next_pc = branch_target;
        end
    end

    // Forwarding muxes and ALU operands
    assign mem_result = exmem_link ? exmem_pc4 : exmem_alu;
    assign alu_a = forward_a[1] ? mem_result : (forward_a[0] ? wb_data : idex_rdat1);
    assign fwd_b = forward_b[1] ? mem_result : (forward_b[0] ? wb_data : idex_rdat2);
    assign alu_b = idex_alu_src ? idex_imm : fwd_b;

    always_comb begin
        if (memwb_link) begin
            wb_data = memwb_pc4;
        end else if (memwb_mem_to_reg) begin
            wb_data = memwb_dload;
        end else begin
            wb_data = memwb_alu;
        end
    end

    // Stage valid bits, PC and halt flag
    always_ff @(posedge CLK) begin
        if (reset) begin
            pc          <= `CPU_PC_INIT;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
            halt        <= 1'b0;
        end else begin
            if (memwb_valid && memwb_halt) begin
                halt <= 1'b1;
            end
            if (advance) begin
                if (!stall && !fetch_stop) begin
                    pc <= next_pc;
                end
                if (!stall) begin
                    ifid_valid <= !fetch_stop && !redirect;
                end
                idex_valid  <= ifid_valid && !stall;
                exmem_valid <= idex_valid;
                memwb_valid <= exmem_valid;
            end
        end
    end

    // Stage payloads
    always_ff @(posedge CLK) begin
        if (advance) begin
            if (!stall) begin
                ifid_instr <= imemload;
                ifid_pc4   <= pc_plus4;
            end
            idex_pc4        <= ifid_pc4;
            idex_rdat1      <= rdat1;
            idex_rdat2      <= rdat2;
            idex_imm        <= id_imm;
            idex_rs         <= id_rs;
            idex_rt         <= id_rt;
            idex_dest       <= id_dest;
            idex_alu_op     <= alu_op;
            idex_alu_src    <= alu_src;
            idex_mem_to_reg <= mem_to_reg;
            idex_reg_wen    <= reg_wen;
            idex_dren       <= id_dren;
            idex_dwen       <= id_dwen;
            idex_link       <= jump_link;
            idex_halt       <= halt_op;
            exmem_pc4        <= idex_pc4;
            exmem_alu        <= alu_out;
            exmem_store      <= fwd_b;
            exmem_dest       <= idex_dest;
            exmem_mem_to_reg <= idex_mem_to_reg;
            exmem_reg_wen    <= idex_reg_wen;
            exmem_dren       <= idex_dren;
            exmem_dwen       <= idex_dwen;
            exmem_link       <= idex_link;
            exmem_halt       <= idex_halt;
            memwb_pc4        <= exmem_pc4;
            memwb_alu        <= exmem_alu;
            memwb_dload      <= dmemload;
            memwb_dest       <= exmem_dest;
            memwb_mem_to_reg <= exmem_mem_to_reg;
            memwb_reg_wen    <= exmem_reg_wen;
            memwb_link       <= exmem_link;
            memwb_halt       <= exmem_halt;
        end
    end

    register_file i_register_file (
        .CLK(CLK), .reset(reset), .wen(memwb_valid && memwb_reg_wen),
        .wsel(memwb_dest), .wdat(wb_data), .rsel1(id_rs), .rsel2(id_rt),
        .rdat1(rdat1), .rdat2(rdat2)
    );

    control_unit i_control_unit (
        .opcode(cpu_types_pkg::opcode_t'(ifid_instr[31:26])),
        .funct(cpu_types_pkg::funct_t'(ifid_instr[5:0])),
        .reg_dst(reg_dst), .alu_src(alu_src), .ext_signed(ext_signed),
        .mem_to_reg(mem_to_reg), .reg_wen(reg_wen), .dmem_ren(id_dren),
        .dmem_wen(id_dwen), .branch_eq(branch_eq), .branch_ne(branch_ne),
        .jump(jump), .jump_link(jump_link), .jump_reg(jump_reg),
        .halt_op(halt_op), .alu_op(alu_op)
    );

    hazard_unit i_hazard_unit (
        .id_rs(id_rs), .id_rt(id_rt), .ex_dest(idex_dest), .mem_dest(exmem_dest),
        .wb_dest(memwb_dest), .ex_rs(idex_rs), .ex_rt(idex_rt),
        .ex_wen(idex_valid && idex_reg_wen), .mem_wen(exmem_valid && exmem_reg_wen),
        .wb_wen(memwb_valid && memwb_reg_wen), .ex_load(idex_valid && idex_dren),
        .id_uses_rt(reg_dst || id_dwen || branch_eq || branch_ne),
        .id_compare(branch_eq || branch_ne || jump_reg),
        .load_stall(load_stall), .branch_stall(branch_stall),
        .forward_a(forward_a), .forward_b(forward_b)
    );

    alu i_alu (
        .port_a(alu_a), .port_b(alu_b), .alu_op(idex_alu_op), .out_port(alu_out)
    );

    // Memory ports
    assign imem_ren  = 1'b1;
    assign imemaddr  = pc;
    assign dmem_ren  = exmem_valid && exmem_dren;
    assign dmem_wen  = exmem_valid && exmem_dwen;
    assign dmemaddr  = exmem_alu;
    assign dmemstore = exmem_store;

endmodule

/* logic/hazard_unit.sv */
// Stall and forwarding logic
`timescale 1ns/10ps

module hazard_unit (
    input  cpu_types_pkg::regbits_t id_rs,
    input  cpu_types_pkg::regbits_t id_rt,
    input  cpu_types_pkg::regbits_t ex_dest,
    input  cpu_types_pkg::regbits_t mem_dest,
    input  cpu_types_pkg::regbits_t wb_dest,
    input  cpu_types_pkg::regbits_t ex_rs,
    input  cpu_types_pkg::regbits_t ex_rt,
    input  logic                    ex_wen,
    input  logic                    mem_wen,
    input  logic                    wb_wen,
    input  logic                    ex_load,
    input  logic                    id_uses_rt,
    input  logic                    id_compare,
    output logic                    load_stall,
    output logic                    branch_stall,
    output logic [1:0]              forward_a,
    output logic [1:0]              forward_b
);
    logic ex_hit, mem_hit;

    // Memory stage result wins over writeback
    function automatic logic [1:0] fwd_sel(
        input cpu_types_pkg::regbits_t src,
        input cpu_types_pkg::regbits_t m_dest,
        input logic                    m_wen,
        input cpu_types_pkg::regbits_t w_dest,
        input logic                    w_wen
    );
        if (src == '0) begin
            return 2'b00;
        end
        if (m_wen && m_dest == src) begin
            return 2'b10;
        end
        return (w_wen && w_dest == src) ? 2'b01 : 2'b00;
    endfunction

    // Pending writes that a decode source depends on
    assign ex_hit = ex_wen && ex_dest != '0 &&
                    (ex_dest == id_rs || (id_uses_rt && ex_dest == id_rt));
    assign mem_hit = mem_wen && mem_dest != '0 &&
                     (mem_dest == id_rs || (id_uses_rt && mem_dest == id_rt));

    assign load_stall   = ex_load && ex_hit;
    assign branch_stall = id_compare && (ex_hit || mem_hit);

    assign forward_a = fwd_sel(ex_rs, mem_dest, mem_wen, wb_dest, wb_wen);
    assign forward_b = fwd_sel(ex_rt, mem_dest, mem_wen, wb_dest, wb_wen);

endmodule

/* logic/register_file.sv */
// Register file
`timescale 1ns/10ps
`include "cpu_consts.svh"

module register_file (
    input  logic                    CLK,
    input  logic                    reset,
    input  logic                    wen,
    input  cpu_types_pkg::regbits_t wsel,
    input  cpu_types_pkg::word_t    wdat,
    input  cpu_types_pkg::regbits_t rsel1,
    input  cpu_types_pkg::regbits_t rsel2,
    output cpu_types_pkg::word_t    rdat1,
    output cpu_types_pkg::word_t    rdat2
);
    cpu_types_pkg::word_t regs [`CPU_REG_COUNT];

    // Register 0 is never written, so it stays at zero from reset
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdat;
        end
    end

    // Bypass of the write port so decode sees the writeback value
    assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule
